/* Bender.yml */
package:
  name: vga_linear

sources:
  - src/vga_pkg.sv
  - src/vga_crtc_timing.sv
  - src/vga_linear_fetch.sv
  - src/vga_plane_ram.sv
  - src/vga_dac_palette.sv
  - src/vga_linear_top.sv
  - target: test
    files:
      - dv/tb_vga_linear.sv

/* dv/tb_vga_linear.sv */
// Testbench for the VGA linear mode display path
// Random frames scanned dot by dot and checked against a reference model
`default_nettype none

module tb_vga_linear;

  import vga_pkg::*;

  localparam int WAIT_LIMIT  = 4 * H_TOTAL * V_TOTAL;
  localparam int PLANE_WORDS = 1 << (VRAM_ADDR_W - 2);

  logic                   clk;
  logic                   rst;
  host_op_e               host_op;
  logic [VRAM_ADDR_W-1:0] host_addr;
  logic [VRAM_DATA_W-1:0] host_data;
  logic [RGB_W-1:0]       rgb;
  logic                   hsync, vsync, de, pix_en;

  // Shadow copies of VRAM colour indices and palette entries
  logic [COLOR_W-1:0] vram_sh [1 << VRAM_ADDR_W];
  logic [RGB_W-1:0]   pal_sh [1 << COLOR_W];

  logic [31:0] rng_state;
  logic        cmp_en;
  int          col_cnt, line_cnt, line_idx, frame_cnt;
  int          hs_period, hs_width, vs_width;
  logic        hs_seen, hs_q, vs_q, de_q, pe_q;

  vga_linear_top #(.FETCH_DEPTH(5)) dut0 (
    .clk, .rst, .host_op_i(host_op), .host_addr_i(host_addr), .host_data_i(host_data),
    .rgb_o(rgb), .hsync_o(hsync), .vsync_o(vsync), .de_o(de), .pix_en_o(pix_en)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Plane is x mod 4 and offset is 80 words per row plus x div 4
  function automatic logic [VRAM_ADDR_W-1:0] pixel_addr(input int x, input int y);
    return VRAM_ADDR_W'((x % 4) * PLANE_WORDS + y * 80 + x / 4);
  endfunction

  function automatic logic [RGB_W-1:0] expected_rgb(input int x, input int y);
    return pal_sh[vram_sh[pixel_addr(x, y)]];
  endfunction

  task automatic report_failure(input string what);
    $display("Test FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic check_rgb(input string name, input logic [RGB_W-1:0] got,
                           input logic [RGB_W-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      report_failure("wrong RGB value on the display output");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      report_failure("wrong level on a display control output");
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure("wrong display timing");
    end
  endtask

  // One host command per clk
  // A NOP closes each burst
  task automatic host_write(input host_op_e op, input int addr, input logic [15:0] data);
    @(posedge clk);
    host_op   <= op;
    host_addr <= VRAM_ADDR_W'(addr);
    host_data <= data;
  endtask

  task automatic load_vram_pixel(input int x, input int y);
    rng_state = lcg_step(rng_state);
    vram_sh[pixel_addr(x, y)] = rng_state[23:16];
    host_write(HOST_WR_VRAM, pixel_addr(x, y), rng_state[31:16]);
  endtask

  // DAC keeps only the low 12 data bits
  task automatic load_palette_entry(input int idx);
    rng_state = lcg_step(rng_state);
    pal_sh[idx] = rng_state[27:16];
    host_write(HOST_WR_PAL, idx, rng_state[31:16]);
  endtask

  task automatic wait_frame_start();
    int start;
    int n;
    start = frame_cnt;
    n = 0;
    while (frame_cnt == start)
    begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
        report_failure("timed out waiting for vsync_o to rise");
    end
  endtask

  task automatic wait_active_line();
    int n;
    n = 0;
    while (line_cnt == 0)
    begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
        report_failure("timed out waiting for the first active line");
    end
  endtask

  // Scanner samples once per dot while outputs are stable
  always @(negedge clk)
  begin
    if (!rst)
    begin
      // Dot enable toggles on every clk
      check_bit("pix_en_o", pix_en, ~pe_q);
      pe_q = pix_en;
    end
    if (!rst && pix_en)
    begin
      hs_period++;
      if (hsync && !hs_q)
      begin
        if (hs_seen)
          check_count("hsync_o period", hs_period, H_TOTAL);
        hs_period = 0;
        hs_seen   = 1'b1;
      end
      if (hsync)
        hs_width++;
      else if (hs_q)
      begin
        check_count("hsync_o width", hs_width, H_SYNC);
        hs_width = 0;
      end
      // Frame boundary at vsync rise
      if (vsync && !vs_q)
      begin
        check_count("de_o lines per frame", line_cnt, V_ACTIVE);
        line_cnt = 0;
        frame_cnt++;
      end
      if (vsync)
        vs_width++;
      else if (vs_q)
      begin
        check_count("vsync_o width", vs_width, V_SYNC * H_TOTAL);
        vs_width = 0;
      end
      if (de && !de_q)
      begin
        col_cnt  = 0;
        line_idx = line_cnt;
        line_cnt++;
      end
      if (de)
      begin
        // Each source pixel is doubled in both directions
        if (cmp_en)
          check_rgb($sformatf("rgb_o x=%0d y=%0d", col_cnt / 2, line_idx / 2), rgb,
                    expected_rgb(col_cnt / 2, line_idx / 2));
        col_cnt++;
      end
      else
      begin
        check_rgb("rgb_o blanked", rgb, '0);
        if (de_q)
          check_count("de_o line length", col_cnt, H_ACTIVE);
      end
      hs_q = hsync;
      vs_q = vsync;
      de_q = de;
    end
  end

  initial
  begin
    clk       = 1'b0;
    rst       = 1'b1;
    host_op   = HOST_NOP;
    host_addr = '0;
    host_data = '0;
    rng_state = 32'hff89;
    cmp_en    = 1'b0;
    {col_cnt, line_cnt, line_idx, frame_cnt} = '0;
    {hs_period, hs_width, vs_width} = '0;
    {hs_seen, hs_q, vs_q, de_q} = '0;
    pe_q      = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // Outputs still at reset values before the first dot step
    @(negedge clk);
    check_bit("pix_en_o", pix_en, 1'b0);
    check_bit("hsync_o", hsync, 1'b0);
    check_bit("vsync_o", vsync, 1'b0);
    check_bit("de_o", de, 1'b0);
    check_rgb("rgb_o", rgb, '0);
    // Full palette and a full 320x200 frame
    for (int i = 0; i < (1 << COLOR_W); i++)
      load_palette_entry(i);
    for (int y = 0; y < V_ACTIVE / 2; y++)
      for (int x = 0; x < H_ACTIVE / 2; x++)
        load_vram_pixel(x, y);
    host_write(HOST_NOP, 0, '0);
    wait_frame_start();
    cmp_en = 1'b1;
    wait_frame_start();
    // New palette entries during vertical blanking
    for (int i = 0; i < 64; i++)
    begin
      rng_state = lcg_step(rng_state);
      load_palette_entry(int'(rng_state[23:16]));
    end
    host_write(HOST_NOP, 0, '0);
    wait_frame_start();
    // Band of rows rewritten while the frame is on screen
    wait_active_line();
    cmp_en = 1'b0;
    for (int y = 40; y < 60; y++)
      for (int x = 0; x < H_ACTIVE / 2; x++)
        load_vram_pixel(x, y);
    host_write(HOST_NOP, 0, '0);
    wait_frame_start();
    cmp_en = 1'b1;
    wait_frame_start();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
src/vga_pkg.sv
src/vga_crtc_timing.sv
src/vga_linear_fetch.sv
src/vga_plane_ram.sv
src/vga_dac_palette.sv
src/vga_linear_top.sv
dv/tb_vga_linear.sv

/* src/vga_crtc_timing.sv */
// CRT timing generator
// Dot-clock enable, scan counters, sync pulses and active-region flags
`default_nettype none

module vga_crtc_timing (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      pix_en_o,
  output logic [vga_pkg::CNT_W-1:0] h_count_o,
  output logic [vga_pkg::CNT_W-1:0] v_count_o,
  output logic                      hsync_o,
  output logic                      vsync_o,
  output logic                      video_on_h_o,
  output logic                      video_on_v_o
);

  import vga_pkg::*;

  // Last dot of each horizontal phase
  localparam logic [CNT_W-1:0] H_ACT_END  = CNT_W'(H_ACTIVE - 1);
  localparam logic [CNT_W-1:0] H_FP_END   = CNT_W'(H_ACTIVE + H_FRONT - 1);
  localparam logic [CNT_W-1:0] H_SYNC_END = CNT_W'(H_ACTIVE + H_FRONT + H_SYNC - 1);
  localparam logic [CNT_W-1:0] H_LAST     = CNT_W'(H_TOTAL - 1);

  // Vertical sync window and last line
  localparam logic [CNT_W-1:0] V_SYNC_BEG = CNT_W'(V_ACTIVE + V_FRONT);
  localparam logic [CNT_W-1:0] V_SYNC_END = CNT_W'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam logic [CNT_W-1:0] V_LAST     = CNT_W'(V_TOTAL - 1);

  h_phase_e h_phase;
  logic     line_end;

  // Dot clock is half of clk
  always_ff @(posedge clk)
  begin
    if (rst)
      pix_en_o <= 1'b0;
    else
      pix_en_o <= ~pix_en_o;
  end

  assign line_end = (h_count_o == H_LAST);

  // Horizontal counter and phase FSM
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      h_count_o <= '0;
      h_phase   <= H_PH_ACTIVE;
    end
    else if (pix_en_o)
    begin
      h_count_o <= line_end ? '0 : h_count_o + 1'b1;
      case (h_phase)
        H_PH_ACTIVE: if (h_count_o == H_ACT_END)  h_phase <= H_PH_FRONT;
        H_PH_FRONT:  if (h_count_o == H_FP_END)   h_phase <= H_PH_SYNC;
        H_PH_SYNC:   if (h_count_o == H_SYNC_END) h_phase <= H_PH_BACK;
        default:     if (line_end)                h_phase <= H_PH_ACTIVE;
      endcase
    end
  end

  // Line counter steps at end of line
  always_ff @(posedge clk)
  begin
    if (rst)
      v_count_o <= '0;
    else if (pix_en_o && line_end)
      v_count_o <= (v_count_o == V_LAST) ? '0 : v_count_o + 1'b1;
  end

  assign hsync_o      = (h_phase == H_PH_SYNC);
  assign video_on_h_o = (h_phase == H_PH_ACTIVE);

  // Vertical flags straight from the line count
  assign vsync_o      = (v_count_o >= V_SYNC_BEG) && (v_count_o < V_SYNC_END);
  assign video_on_v_o = (v_count_o < CNT_W'(V_ACTIVE));

endmodule

`default_nettype wire

/* src/vga_dac_palette.sv */
// Palette DAC
// 256-entry colour lookup to 12-bit RGB, output registers with blanking
`default_nettype none

module vga_dac_palette (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            pix_en_i,
  input  vga_pkg::host_op_e               host_op_i,
  input  logic [vga_pkg::VRAM_ADDR_W-1:0] host_addr_i,
  input  logic [vga_pkg::VRAM_DATA_W-1:0] host_data_i,
  input  logic [vga_pkg::COLOR_W-1:0]     color_i,
  input  logic                            hsync_i,
  input  logic                            vsync_i,
  input  logic                            video_on_i,
  output logic [vga_pkg::RGB_W-1:0]       rgb_o,
  output logic                            hsync_o,
  output logic                            vsync_o,
  output logic                            de_o
);

  import vga_pkg::*;

  localparam int ENTRIES = 1 << COLOR_W;

  // 4 bits each of red, green, blue
  logic [RGB_W-1:0] pal [ENTRIES];

  // Index from address low byte, RGB from data low bits
  always_ff @(posedge clk)
  begin
    if (host_op_i == HOST_WR_PAL)
      pal[host_addr_i[COLOR_W-1:0]] <= host_data_i[RGB_W-1:0];
  end

  // Output stage, one dot step
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rgb_o   <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
    end
    else if (pix_en_i)
    begin
      // Black outside the active area
      rgb_o   <= video_on_i ? pal[color_i] : '0;
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
      de_o    <= video_on_i;
    end
  end

endmodule

`default_nettype wire

/* src/vga_linear_fetch.sv */
// Linear 256-colour fetch unit
// Builds plane-interleaved VRAM addresses, strobes one read per pixel pair,
// latches the colour index and delays sync and blanking to match it
`default_nettype none

module vga_linear_fetch #(
  parameter int FETCH_DEPTH = 5
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            pix_en_i,
  input  logic [vga_pkg::CNT_W-1:0]       h_count_i,
  input  logic [vga_pkg::CNT_W-1:0]       v_count_i,
  input  logic                            hsync_i,
  input  logic                            vsync_i,
  input  logic                            video_on_i,
  output logic [vga_pkg::VRAM_ADDR_W-1:0] vram_adr_o,
  output logic                            vram_stb_o,
  input  logic [vga_pkg::VRAM_DATA_W-1:0] vram_dat_i,
  output logic [vga_pkg::COLOR_W-1:0]     color_o,
  output logic                            hsync_o,
  output logic                            vsync_o,
  output logic                            video_on_o
);

  import vga_pkg::*;

  // Word offset is row base times 16 plus low column bits
  localparam int OFS_W = VRAM_ADDR_W - 2;
  localparam int ROW_W = OFS_W - 4;

  logic [ROW_W-1:0]   row_addr;
  logic [6:0]         col_addr;
  logic [1:0]         plane_addr0;
  logic [1:0]         plane_addr;
  logic [OFS_W-1:0]   word_offset;
  logic [2:0]         pipe;
  logic [COLOR_W-1:0] color_l;

  // One entry per pix_en step, bits are hsync, vsync, video_on
  logic [2:0] sig_dl [FETCH_DEPTH];

  // Marks even dots as they walk down the pipeline
  always_ff @(posedge clk)
  begin
    if (rst)
      pipe <= '0;
    else if (pix_en_i)
      pipe <= {pipe[1:0], ~h_count_i[0]};
  end

  // Address stage 1 then 2
  always_ff @(posedge clk)
  begin
    if (pix_en_i)
    begin
      // Half line number times 5, wraps harmlessly in blanking
      row_addr    <= {v_count_i[8:1], 2'b00} + {2'b00, v_count_i[8:1]};
      col_addr    <= h_count_i[9:3];
      plane_addr0 <= h_count_i[2:1];
      word_offset <= {row_addr + {7'd0, col_addr[6:4]}, col_addr[3:0]};
      plane_addr  <= plane_addr0;
    end
  end

  assign vram_adr_o = {plane_addr, word_offset};
  // Two clk wide, memory answers in the second
  assign vram_stb_o = pipe[1];

  // Capture before the next strobe overwrites the read data
  always_ff @(posedge clk)
  begin
    if (pix_en_i && pipe[2])
      color_l <= vram_dat_i[COLOR_W-1:0];
  end

  // Output stage, one step later to sit with the sync delay
  always_ff @(posedge clk)
  begin
    if (pix_en_i)
      color_o <= color_l;
  end

  // Sync and blanking delay line
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < FETCH_DEPTH; i++)
        sig_dl[i] <= '0;
    end
    else if (pix_en_i)
    begin
      sig_dl[0] <= {hsync_i, vsync_i, video_on_i};
      for (int i = 1; i < FETCH_DEPTH; i++)
        sig_dl[i] <= sig_dl[i-1];
    end
  end

  assign hsync_o    = sig_dl[FETCH_DEPTH-1][2];
  assign vsync_o    = sig_dl[FETCH_DEPTH-1][1];
  assign video_on_o = sig_dl[FETCH_DEPTH-1][0];

endmodule

`default_nettype wire

/* src/vga_linear_top.sv */
// VGA linear mode display path
// Timing generator, fetch unit, plane memory and palette DAC
`default_nettype none

module vga_linear_top #(
  parameter int FETCH_DEPTH = 5
) (
  input  logic                            clk,
  input  logic                            rst,
  input  vga_pkg::host_op_e               host_op_i,
  input  logic [vga_pkg::VRAM_ADDR_W-1:0] host_addr_i,
  input  logic [vga_pkg::VRAM_DATA_W-1:0] host_data_i,
  output logic [vga_pkg::RGB_W-1:0]       rgb_o,
  output logic                            hsync_o,
  output logic                            vsync_o,
  output logic                            de_o,
  output logic                            pix_en_o
);

  import vga_pkg::*;

  logic [CNT_W-1:0]       h_count, v_count;
  logic                   hsync, vsync, video_on_h, video_on_v, video_on;
  logic [VRAM_ADDR_W-1:0] vram_adr;
  logic                   vram_stb;
  logic [VRAM_DATA_W-1:0] vram_dat;
  logic [COLOR_W-1:0]     color_idx;
  logic                   hsync_d, vsync_d, video_on_d;

  vga_crtc_timing u_timing (
    .clk, .rst, .pix_en_o,
    .h_count_o(h_count), .v_count_o(v_count),
    .hsync_o(hsync), .vsync_o(vsync),
    .video_on_h_o(video_on_h), .video_on_v_o(video_on_v)
  );

  // Visible only inside both active regions
  assign video_on = video_on_h & video_on_v;

  vga_linear_fetch #(.FETCH_DEPTH(FETCH_DEPTH)) u_fetch (
    .clk, .rst, .pix_en_i(pix_en_o),
    .h_count_i(h_count), .v_count_i(v_count),
    .hsync_i(hsync), .vsync_i(vsync), .video_on_i(video_on),
    .vram_adr_o(vram_adr), .vram_stb_o(vram_stb), .vram_dat_i(vram_dat),
    .color_o(color_idx), .hsync_o(hsync_d), .vsync_o(vsync_d), .video_on_o(video_on_d)
  );

  vga_plane_ram u_vram (
    .clk, .host_op_i, .host_addr_i, .host_data_i,
    .rd_adr_i(vram_adr), .rd_stb_i(vram_stb), .rd_dat_o(vram_dat)
  );

  vga_dac_palette u_dac (
    .clk, .rst, .pix_en_i(pix_en_o), .host_op_i, .host_addr_i, .host_data_i,
    .color_i(color_idx), .hsync_i(hsync_d), .vsync_i(vsync_d), .video_on_i(video_on_d),
    .rgb_o, .hsync_o, .vsync_o, .de_o
  );

endmodule

`default_nettype wire

/* src/vga_pkg.sv */
// VGA linear mode package
// Fixed 640x400 scan geometry, memory widths and host command encoding
`default_nettype none

package vga_pkg;

  // Horizontal timing in dots
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // Vertical timing in lines
  localparam int V_ACTIVE = 400;
  localparam int V_FRONT  = 12;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 35;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam int CNT_W = 10;

  // Plane in top 2 bits, word offset below
  localparam int VRAM_ADDR_W = 16;
  localparam int VRAM_DATA_W = 16;
  localparam int COLOR_W     = 8;
  localparam int RGB_W       = 12;

  typedef enum logic [1:0] {HOST_NOP, HOST_WR_VRAM, HOST_WR_PAL} host_op_e;

  typedef enum logic [1:0] {H_PH_ACTIVE, H_PH_FRONT, H_PH_SYNC, H_PH_BACK} h_phase_e;

endpackage

`default_nettype wire

/* src/vga_plane_ram.sv */
// Four-plane video memory
// Host write port and a strobed, registered scanout read port
`default_nettype none

module vga_plane_ram (
  input  logic                            clk,
  input  vga_pkg::host_op_e               host_op_i,
  input  logic [vga_pkg::VRAM_ADDR_W-1:0] host_addr_i,
  input  logic [vga_pkg::VRAM_DATA_W-1:0] host_data_i,
  input  logic [vga_pkg::VRAM_ADDR_W-1:0] rd_adr_i,
  input  logic                            rd_stb_i,
  output logic [vga_pkg::VRAM_DATA_W-1:0] rd_dat_o
);

  import vga_pkg::*;

  localparam int WORDS = 1 << VRAM_ADDR_W;

  // Plane select in the top address bits
  logic [VRAM_DATA_W-1:0] mem [WORDS];

  // Host side, one word per command
  always_ff @(posedge clk)
  begin
    if (host_op_i == HOST_WR_VRAM)
      mem[host_addr_i] <= host_data_i;
  end

  // Scanout side
  // Data lands one clk after the strobe and holds until the next one
  always_ff @(posedge clk)
  begin
    if (rd_stb_i)
      rd_dat_o <= mem[rd_adr_i];
  end

endmodule

`default_nettype wire
